// ==== verilog/axi2ram_defines.svh ====
`ifndef AXI2RAM_DEFINES_SVH
`define AXI2RAM_DEFINES_SVH

`define AXI2RAM_AW          32      // axi byte address
`define AXI2RAM_DW          32      // data bus
`define AXI2RAM_RAM_AW      10      // ram word address, 1024 words

`define AXI2RAM_FIFO_DEPTH  2       // entries per channel fifo

// reads owed at once, sized so returning ram data always fits the r fifo
`define AXI2RAM_RD_CREDITS  `AXI2RAM_FIFO_DEPTH

`define AXI2RAM_RAM_LAT     1       // cycles from ram select to r_rvld

`endif

// ==== verilog/axi2ram_pkg.sv ====
`include "axi2ram_defines.svh"

package axi2ram_pkg;

    localparam int LANE_BITS = $clog2(`AXI2RAM_DW / 8);    // byte offset within a word

    typedef logic [`AXI2RAM_AW-1:0]     addr_t;
    typedef logic [`AXI2RAM_DW-1:0]     data_t;
    typedef logic [`AXI2RAM_DW/8-1:0]   strb_t;
    typedef logic [`AXI2RAM_RAM_AW-1:0] ram_addr_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10                  // never produced
    } resp_t;

    typedef addr_t aw_pl_t;
    typedef addr_t ar_pl_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_pl_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
    } r_pl_t;

    typedef resp_t b_pl_t;

    typedef logic [$clog2(`AXI2RAM_RD_CREDITS + 1)-1:0] credit_t;

    // upper bits dropped, so addresses wrap onto the ram
    function automatic ram_addr_t to_ram_addr(addr_t byte_addr);
        return byte_addr[LANE_BITS +: `AXI2RAM_RAM_AW];
    endfunction

endpackage

// ==== verilog/ram_cmd_if.sv ====
interface ram_cmd_if;
    import axi2ram_pkg::*;

    logic      cs;      // one access per cycle
    logic      we;
    ram_addr_t addr;
    strb_t     bwe;     // byte enables, writes only
    data_t     din;

    modport arb (
        output cs,
        output we,
        output addr,
        output bwe,
        output din
    );

    modport port (
        input cs,
        input we,
        input addr,
        input bwe,
        input din
    );
endinterface

// ==== verilog/chan_fifo.sv ====
`include "axi2ram_defines.svh"

module chan_fifo #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int DEPTH = `AXI2RAM_FIFO_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;       // occupancy, 0..DEPTH
    logic          push;
    logic          pop;

    assign in_ready  = (count != (PW+1)'(DEPTH));   // not full
    assign out_valid = (count != '0);               // not empty
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    assign out_data  = mem[rd_ptr];                 // head held until popped

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + {{PW{1'b0}}, push} - {{PW{1'b0}}, pop};
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end
endmodule

// ==== verilog/rd_credit_cnt.sv ====
`include "axi2ram_defines.svh"

module rd_credit_cnt (
    input  logic aclk,
    input  logic rst,
    input  logic rd_issue,      // read granted on the ram port
    input  logic r_done,        // r handshake at the axi port
    output logic credit_ok
);
    import axi2ram_pkg::*;

    credit_t count;             // reads in the ram plus beats waiting in the r fifo

    always_ff @(posedge aclk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({rd_issue, r_done})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;     // none or both
                end
            endcase
        end
    end

    // a read never follows a read directly, so the plain count is enough here
    assign credit_ok = (count < credit_t'(`AXI2RAM_RD_CREDITS));
endmodule

// ==== verilog/ram_rw_arb.sv ====
module ram_rw_arb (
    input  logic               aclk,
    input  logic               rst,
    input  logic               aw_valid,
    input  axi2ram_pkg::aw_pl_t aw_addr,
    output logic               aw_pop,
    input  logic               w_valid,
    input  axi2ram_pkg::w_pl_t w_pl,
    output logic               w_pop,
    input  logic               b_ready,
    output logic               b_push,
    input  logic               ar_valid,
    input  axi2ram_pkg::ar_pl_t ar_addr,
    output logic               ar_pop,
    input  logic               credit_ok,
    output logic               rd_issue,
    ram_cmd_if.arb             ram
);
    import axi2ram_pkg::*;

    typedef enum logic [1:0] {IDLE, WRITE, READ} state_t;

    state_t state;
    state_t state_nxt;
    logic   last_wr;            // side served last, loses a tie
    logic   wr_ready;
    logic   rd_ready;

    assign wr_ready = aw_valid & w_valid & b_ready;
    assign rd_ready = ar_valid & credit_ok;

    // never the same grant twice in a row, the fifo heads need a cycle to advance
    always_comb begin
        state_nxt = IDLE;
        case (state)
            IDLE: begin
                if (wr_ready && (!rd_ready || !last_wr)) begin
                    state_nxt = WRITE;
                end else if (rd_ready) begin
                    state_nxt = READ;
                end
            end
            WRITE: begin
                if (rd_ready) begin
                    state_nxt = READ;
                end
            end
            READ: begin
                if (wr_ready) begin
                    state_nxt = WRITE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= IDLE;
            last_wr <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == WRITE) begin
                last_wr <= 1'b1;
            end else if (state == READ) begin
                last_wr <= 1'b0;
            end
        end
    end

    assign aw_pop   = (state == WRITE);
    assign w_pop    = (state == WRITE);
    assign b_push   = (state == WRITE);     // response queued with the access
    assign ar_pop   = (state == READ);
    assign rd_issue = (state == READ);

    assign ram.cs   = (state != IDLE);
    assign ram.we   = (state == WRITE);
    assign ram.addr = (state == WRITE) ? to_ram_addr(aw_addr) : to_ram_addr(ar_addr);
    assign ram.bwe  = (state == WRITE) ? w_pl.strb : '0;
    assign ram.din  = (state == WRITE) ? w_pl.data : '0;
endmodule

// ==== verilog/axi2ram_top.sv ====
module axi2ram_top (
    input  logic                   aclk,
    input  logic                   rst,
    input  axi2ram_pkg::addr_t     awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  axi2ram_pkg::data_t     wdata,
    input  axi2ram_pkg::strb_t     wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output axi2ram_pkg::resp_t     bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  axi2ram_pkg::addr_t     araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output axi2ram_pkg::data_t     rdata,
    output axi2ram_pkg::resp_t     rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output axi2ram_pkg::ram_addr_t r_addr,
    output logic                   r_cs_n,
    output logic                   r_we_n,
    output axi2ram_pkg::strb_t     r_bwe,
    output axi2ram_pkg::data_t     r_din,
    input  axi2ram_pkg::data_t     r_dout,
    input  logic                   r_rvld
);
    import axi2ram_pkg::*;

    logic   aw_valid;
    aw_pl_t aw_addr;
    logic   aw_pop;
    logic   w_valid;
    w_pl_t  w_in;
    w_pl_t  w_pl;
    logic   w_pop;
    logic   b_ready;            // room in the b fifo
    logic   b_push;
    logic   ar_valid;
    ar_pl_t ar_addr;
    logic   ar_pop;
    r_pl_t  r_in;
    r_pl_t  r_out;
    logic   r_done;
    logic   rd_issue;
    logic   credit_ok;

    ram_cmd_if ram_if ();

    assign w_in   = '{data: wdata, strb: wstrb};
    assign r_in   = '{data: r_dout, resp: OKAY};    // every read is OKAY
    assign rdata  = r_out.data;
    assign rresp  = r_out.resp;
    assign r_done = rvalid & rready;

    // active-low ram strobes
    assign r_cs_n = ~ram_if.cs;
    assign r_we_n = ~ram_if.we;
    assign r_addr = ram_if.addr;
    assign r_bwe  = ram_if.bwe;
    assign r_din  = ram_if.din;

    chan_fifo #(.payload_t(aw_pl_t)) aw_fifo_i (
        .aclk      (aclk),
        .rst       (rst),
        .in_valid  (awvalid),
        .in_ready  (awready),
        .in_data   (awaddr),
        .out_valid (aw_valid),
        .out_ready (aw_pop),
        .out_data  (aw_addr)
    );

    chan_fifo #(.payload_t(w_pl_t)) w_fifo_i (
        .aclk      (aclk),
        .rst       (rst),
        .in_valid  (wvalid),
        .in_ready  (wready),
        .in_data   (w_in),
        .out_valid (w_valid),
        .out_ready (w_pop),
        .out_data  (w_pl)
    );

    chan_fifo #(.payload_t(b_pl_t)) b_fifo_i (
        .aclk      (aclk),
        .rst       (rst),
        .in_valid  (b_push),
        .in_ready  (b_ready),
        .in_data   (OKAY),
        .out_valid (bvalid),
        .out_ready (bready),
        .out_data  (bresp)
    );

    chan_fifo #(.payload_t(ar_pl_t)) ar_fifo_i (
        .aclk      (aclk),
        .rst       (rst),
        .in_valid  (arvalid),
        .in_ready  (arready),
        .in_data   (araddr),
        .out_valid (ar_valid),
        .out_ready (ar_pop),
        .out_data  (ar_addr)
    );

    // room guaranteed by the read credits, so no ready goes back to the ram
    chan_fifo #(.payload_t(r_pl_t)) r_fifo_i (
        .aclk      (aclk),
        .rst       (rst),
        .in_valid  (r_rvld),
        .in_ready  (),
        .in_data   (r_in),
        .out_valid (rvalid),
        .out_ready (rready),
        .out_data  (r_out)
    );

    ram_rw_arb arb_i (
        .aclk      (aclk),
        .rst       (rst),
        .aw_valid  (aw_valid),
        .aw_addr   (aw_addr),
        .aw_pop    (aw_pop),
        .w_valid   (w_valid),
        .w_pl      (w_pl),
        .w_pop     (w_pop),
        .b_ready   (b_ready),
        .b_push    (b_push),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_pop    (ar_pop),
        .credit_ok (credit_ok),
        .rd_issue  (rd_issue),
        .ram       (ram_if)
    );

    rd_credit_cnt credit_i (
        .aclk      (aclk),
        .rst       (rst),
        .rd_issue  (rd_issue),
        .r_done    (r_done),
        .credit_ok (credit_ok)
    );
endmodule

// ==== verif/axi2ram_checker.sv ====
`include "axi2ram_defines.svh"

module axi2ram_checker (
    input logic                 aclk,
    input logic                 rst,
    input logic                 awvalid,
    input logic                 awready,
    input logic                 wvalid,
    input logic                 wready,
    input logic                 bvalid,
    input logic                 bready,
    input logic                 arvalid,
    input logic                 arready,
    input logic                 rvalid,
    input logic                 rready,
    input logic                 r_cs_n,
    input logic                 r_rvld,
    input logic                 r_fifo_ready,   // room in the internal r fifo
    input axi2ram_pkg::credit_t credit_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import axi2ram_pkg::*;

    aw_hold: assert property (@(posedge aclk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge aclk) disable iff (rst) wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");
    ar_hold: assert property (@(posedge aclk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");
    b_hold: assert property (@(posedge aclk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    r_hold: assert property (@(posedge aclk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // arbiter leaves reset in IDLE
    cs_after_rst: assert property (@(posedge aclk) $fell(rst) |-> r_cs_n)
        else $error("ram selected in the first cycle after reset");

    rvld_room: assert property (@(posedge aclk) disable iff (rst) r_rvld |-> r_fifo_ready)
        else $error("ram read data arrived while the r fifo was full");

    credit_max: assert property (@(posedge aclk) disable iff (rst)
        credit_count <= credit_t'(`AXI2RAM_RD_CREDITS))
        else $error("read credit count above its limit");
endmodule

// ==== verif/axi2ram_tb.sv ====
`include "axi2ram_defines.svh"

module axi2ram_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import axi2ram_pkg::*;

    localparam string STIM_FILE = "verif/axi2ram_stimulus.txt";
    localparam int    RAM_WORDS = 1 << `AXI2RAM_RAM_AW;

    typedef struct {
        byte   op;
        addr_t addr;
        data_t data;
        strb_t strb;
        data_t exp_data;
        bit    bp;
    } stim_t;

    logic      aclk = 1'b0;
    logic      rst = 1'b1;
    addr_t     awaddr = '0;
    logic      awvalid = 1'b0;
    logic      awready;
    data_t     wdata = '0;
    strb_t     wstrb = '0;
    logic      wvalid = 1'b0;
    logic      wready;
    resp_t     bresp;
    logic      bvalid;
    logic      bready = 1'b1;
    addr_t     araddr = '0;
    logic      arvalid = 1'b0;
    logic      arready;
    data_t     rdata;
    resp_t     rresp;
    logic      rvalid;
    logic      rready = 1'b1;
    ram_addr_t r_addr;
    logic      r_cs_n;
    logic      r_we_n;
    strb_t     r_bwe;
    data_t     r_din;
    data_t     r_dout = '0;
    logic      r_rvld = 1'b0;

    data_t       ram [RAM_WORDS];
    stim_t       stim_q [$];
    data_t       exp_r [$];         // read data still owed, in issue order
    int          pending_b = 0;
    int          cycles = 0;
    int          max_cycles = 1000;
    bit          bp_on = 1'b0;
    logic [31:0] rnd = 32'd38;

    always #10 aclk = ~aclk;

    axi2ram_top axi2ram_top_i (.*);

    bind axi2ram_top axi2ram_checker checker_i (
        .aclk         (aclk),
        .rst          (rst),
        .awvalid      (awvalid),
        .awready      (awready),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready),
        .arvalid      (arvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .rready       (rready),
        .r_cs_n       (r_cs_n),
        .r_rvld       (r_rvld),
        .r_fifo_ready (r_fifo_i.in_ready),
        .credit_count (credit_i.count)
    );

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] <= 32'h5a000000 ^ (i * 32'h00010101);    // every word distinct
        end
    end

    // single-port ram, read data one cycle after select
    always @(posedge aclk) begin
        r_rvld <= !rst && !r_cs_n && r_we_n;
        if (!rst && !r_cs_n) begin
            if (!r_we_n) begin
                for (int b = 0; b < $bits(strb_t); b++) begin
                    if (r_bwe[b]) begin
                        ram[r_addr][8*b +: 8] <= r_din[8*b +: 8];
                    end
                end
            end else begin
                r_dout <= ram[r_addr];
            end
        end
    end

    function automatic logic [31:0] next_random(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_resp(string name, resp_t exp, resp_t act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        stim_t st;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %d", st.op, st.addr, st.data, st.strb,
                            st.exp_data, st.bp);
                if (n != 6) begin
                    $display("stimulus line could not be parsed: %s", line);
                    abort_run();
                end
                stim_q.push_back(st);
            end
        end
        $fclose(fd);
    endtask

    // called on a falling edge, ready is stable until the next rising edge
    task automatic send_write(addr_t addr, data_t data, strb_t strb);
        bit aw_left;
        bit w_left;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        aw_left = 1'b1;
        w_left  = 1'b1;
        while (aw_left || w_left) begin
            if (awvalid && awready) aw_left = 1'b0;
            if (wvalid && wready) w_left = 1'b0;
            @(negedge aclk);
            if (!aw_left) awvalid = 1'b0;
            if (!w_left) wvalid = 1'b0;
        end
    endtask

    task automatic send_read(addr_t addr);
        bit ar_left;
        araddr  = addr;
        arvalid = 1'b1;
        ar_left = 1'b1;
        while (ar_left) begin
            if (arready) ar_left = 1'b0;
            @(negedge aclk);
        end
        arvalid = 1'b0;
    endtask

    task automatic check_reset_state();
        check_flag("bvalid", 1'b0, bvalid);
        check_flag("rvalid", 1'b0, rvalid);
        check_flag("r_cs_n", 1'b1, r_cs_n);
        check_flag("r_we_n", 1'b1, r_we_n);
        check_flag("awready", 1'b1, awready);
        check_flag("wready", 1'b1, wready);
        check_flag("arready", 1'b1, arready);
    endtask

    // ready toggling and response checks share one falling-edge process
    always @(negedge aclk) begin
        if (!rst) begin
            if (bp_on) begin
                rnd    = next_random(rnd);
                bready = rnd[3];
                rready = rnd[7];
            end else begin
                bready = 1'b1;
                rready = 1'b1;
            end
            if (bvalid && bready) begin
                if (pending_b == 0) begin
                    $display("a B response arrived with no write outstanding");
                    abort_run();
                end else begin
                    check_resp("bresp", OKAY, bresp);
                    pending_b--;
                end
            end
            if (rvalid && rready) begin
                if (exp_r.size() == 0) begin
                    $display("an R beat arrived with no read outstanding");
                    abort_run();
                end else begin
                    check_data("rdata", exp_r.pop_front(), rdata);
                    check_resp("rresp", OKAY, rresp);
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: responses still missing after %0d cycles", max_cycles);
            abort_run();
        end
    end

    initial begin
        stim_t st;
        load_stimulus();
        max_cycles = 40 * stim_q.size() + 10;
        repeat (10) @(negedge aclk);
        rst = 1'b0;
        check_reset_state();
        while (stim_q.size() > 0) begin
            st    = stim_q.pop_front();
            bp_on = st.bp;
            if (st.op == "W") begin
                while (exp_r.size() != 0) @(negedge aclk);   // earlier reads finish first
                pending_b++;
                send_write(st.addr, st.data, st.strb);
            end else if (st.op == "R") begin
                while (pending_b != 0) @(negedge aclk);      // earlier writes land first
                exp_r.push_back(st.exp_data);
                send_read(st.addr);
            end else begin
                $display("unknown operation in the stimulus file: %c", st.op);
                abort_run();
            end
        end
        while (pending_b != 0 || exp_r.size() != 0) @(negedge aclk);
        repeat (20) @(negedge aclk);    // let any stray response show up
        $display("ALL CHECKS PASSED");
        $finish;
    end
endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/axi2ram_pkg.sv
verilog/ram_cmd_if.sv
verilog/chan_fifo.sv
verilog/rd_credit_cnt.sv
verilog/ram_rw_arb.sv
verilog/axi2ram_top.sv
verif/axi2ram_checker.sv
verif/axi2ram_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = axi2ram_tb
FILELIST = vlog.f
PASS_MSG = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== verif/axi2ram_stimulus.txt ====
# op addr data strb expect bp   (hex fields, op W or R, bp 1 = random bready and rready)
# W lines check bresp only, R lines check rdata against expect
W 00000000 11223344 f 00000000 0
W 00000004 a5a5a5a5 f 00000000 0
W 00000008 deadbeef f 00000000 0
R 00000000 00000000 0 11223344 0
R 00000004 00000000 0 a5a5a5a5 0
R 00000008 00000000 0 deadbeef 0
# partial strobes over known words
W 00000004 00ff00ff 5 00000000 0
W 00000008 12345678 c 00000000 0
R 00000004 00000000 0 a5ffa5ff 0
R 00000008 00000000 0 1234beef 0
# addresses differing above ram bit 11
W 00000010 cafef00d f 00000000 0
R 00001010 00000000 0 cafef00d 0
W 00fff014 0badc0de f 00000000 0
R 00000014 00000000 0 0badc0de 0
# back to back reads under rready back-pressure
R 00000000 00000000 0 11223344 1
R 00000004 00000000 0 a5ffa5ff 1
R 00000008 00000000 0 1234beef 1
R 00000010 00000000 0 cafef00d 1
R 00001014 00000000 0 0badc0de 1
R 00000000 00000000 0 11223344 1
# interleaved writes and reads under bready back-pressure
W 00000020 01020304 f 00000000 1
W 00000024 05060708 f 00000000 1
R 00000020 00000000 0 01020304 1
W 00000020 ffffffff 3 00000000 1
R 00000020 00000000 0 0102ffff 1
R 00000024 00000000 0 05060708 1
W 00000028 89abcdef f 00000000 1
W 00000024 00000000 8 00000000 1
R 00000028 00000000 0 89abcdef 1
R 00000024 00000000 0 00060708 1
